// File: all.f
design/rdma_pkg.sv
design/rdma_sq_ctrl.sv
design/mem_cmd_gen.sv
design/tx_hdr_gen.sv
design/rx_ack_check.sv
design/rdma_sq_top.sv
tests/tb_rdma_sq.sv

// File: design/mem_cmd_gen.sv
// Memory command generator that routes issued requests to the read or write port
`timescale 1ns/1ps

module mem_cmd_gen (
  input  logic                   nclk,
  input  logic                   nresetn,
  input  rdma_pkg::rdma_issue_t  issue,
  input  logic                   issue_valid,
  output logic                   issue_ready,
  output rdma_pkg::mem_cmd_t     m_mem_rd,
  output logic                   m_mem_rd_valid,
  input  logic                   m_mem_rd_ready,
  output rdma_pkg::mem_cmd_t     m_mem_wr,
  output logic                   m_mem_wr_valid,
  input  logic                   m_mem_wr_ready
);

  rdma_pkg::mem_cmd_t              cmd;
  logic [rdma_pkg::PSN_BITS-1:0]   last_psn;
  logic                            seen, dup, take, draining;

  // Request stays on the issue link until the header side has it too
  assign dup         = seen && (issue.psn == last_psn);
  assign draining    = (m_mem_rd_valid & m_mem_rd_ready) | (m_mem_wr_valid & m_mem_wr_ready);
  assign issue_ready = ((~m_mem_rd_valid & ~m_mem_wr_valid) | draining) & ~dup;
  assign take        = issue_valid & issue_ready;

  assign m_mem_rd = cmd;
  assign m_mem_wr = cmd;

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      m_mem_rd_valid <= 1'b0;
      m_mem_wr_valid <= 1'b0;
      seen           <= 1'b0;
    end else if (take) begin
      // READ lands the response, WRITE and SEND fetch the payload
      m_mem_rd_valid <= (issue.req.op != rdma_pkg::OP_READ);
      m_mem_wr_valid <= (issue.req.op == rdma_pkg::OP_READ);
      seen           <= 1'b1;
    end else if (draining) begin
      m_mem_rd_valid <= 1'b0;
      m_mem_wr_valid <= 1'b0;
    end
  end

  always_ff @(posedge nclk) begin
    if (take) begin
      cmd.vaddr <= issue.req.vaddr;
      cmd.len   <= issue.req.len;
      cmd.qpn   <= issue.req.qpn;
      last_psn  <= issue.psn;
    end
  end

endmodule

// File: design/rdma_pkg.sv
// Widths, opcode and state enums, and the packed structs of the send-queue front end
package rdma_pkg;

  localparam int QPN_BITS        = 10;
  localparam int PSN_BITS        = 24;
  localparam int VADDR_BITS      = 48;
  localparam int LEN_BITS        = 28;
  localparam int MAX_OUTSTANDING = 8;
  // Holds 0 through MAX_OUTSTANDING
  localparam int CNT_BITS        = 4;

  // User opcode on the send queue
  typedef enum logic [1:0] {
    OP_READ  = 2'd0,
    OP_WRITE = 2'd1,
    OP_SEND  = 2'd2
  } rdma_op_e;

  // RoCE BTH opcodes, RC transport
  typedef enum logic [7:0] {
    BTH_SEND_ONLY  = 8'h04,
    BTH_WRITE_ONLY = 8'h0A,
    BTH_READ_REQ   = 8'h0C
  } bth_op_e;

  typedef enum logic {
    ST_IDLE,
    ST_ISSUE
  } sq_state_e;

  typedef struct packed {
    rdma_op_e              op;
    logic [QPN_BITS-1:0]   qpn;
    logic [VADDR_BITS-1:0] vaddr;
    logic [LEN_BITS-1:0]   len;
  } rdma_sq_t;

  typedef struct packed {
    rdma_sq_t            req;
    logic [PSN_BITS-1:0] psn;
  } rdma_issue_t;

  typedef struct packed {
    logic [VADDR_BITS-1:0] vaddr;
    logic [LEN_BITS-1:0]   len;
    logic [QPN_BITS-1:0]   qpn;
  } mem_cmd_t;

  typedef struct packed {
    bth_op_e             bth_op;
    logic [QPN_BITS-1:0] qpn;
    logic [PSN_BITS-1:0] psn;
    logic [LEN_BITS-1:0] len;
    logic [31:0]         src_ip;
  } tx_hdr_t;

  typedef struct packed {
    logic [QPN_BITS-1:0] qpn;
    logic [PSN_BITS-1:0] psn;
    logic                is_nak;
    logic [7:0]          chk;
  } ack_pkt_t;

  typedef struct packed {
    logic [QPN_BITS-1:0] qpn;
    logic [PSN_BITS-1:0] psn;
    logic                is_nak;
  } ack_meta_t;

endpackage

// File: design/rdma_sq_ctrl.sv
// Send-queue control FSM with outstanding limit, PSN assignment and issue handoff
`timescale 1ns/1ps

module rdma_sq_ctrl (
  input  logic                   nclk,
  input  logic                   nresetn,
  input  rdma_pkg::rdma_sq_t     s_sq,
  input  logic                   s_sq_valid,
  output logic                   s_sq_ready,
  output rdma_pkg::rdma_issue_t  issue,
  output logic                   issue_valid,
  input  logic                   mem_issue_ready,
  input  logic                   hdr_issue_ready,
  input  logic                   ack_done
);

  rdma_pkg::sq_state_e             state, state_n;
  logic [rdma_pkg::CNT_BITS-1:0]   cnt, cnt_n;
  logic [rdma_pkg::PSN_BITS-1:0]   next_psn;
  logic                            mem_taken, hdr_taken;
  logic                            sq_fire, mem_done, hdr_done;

  assign issue_valid = (state == rdma_pkg::ST_ISSUE);
  assign sq_fire     = s_sq_valid & s_sq_ready;

  // A side counts as done once it has taken the request, now or earlier
  assign mem_done = mem_taken | (issue_valid & mem_issue_ready);
  assign hdr_done = hdr_taken | (issue_valid & hdr_issue_ready);

  always_comb begin
    state_n = state;
    case (state)
      rdma_pkg::ST_IDLE: begin
        if (sq_fire) state_n = rdma_pkg::ST_ISSUE;
      end
      rdma_pkg::ST_ISSUE: begin
        if (mem_done && hdr_done) state_n = rdma_pkg::ST_IDLE;
      end
      default: state_n = rdma_pkg::ST_IDLE;
    endcase
  end

  // Admit and ack in the same cycle cancel out
  always_comb begin
    case ({sq_fire, ack_done})
      2'b10:   cnt_n = cnt + 1'b1;
      2'b01:   cnt_n = cnt - 1'b1;
      default: cnt_n = cnt;
    endcase
  end

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      state      <= rdma_pkg::ST_IDLE;
      cnt        <= '0;
      next_psn   <= '0;
      mem_taken  <= 1'b0;
      hdr_taken  <= 1'b0;
      s_sq_ready <= 1'b0;
    end else begin
      state      <= state_n;
      cnt        <= cnt_n;
      // Ready follows the next state so it matches IDLE and below limit
      s_sq_ready <= (state_n == rdma_pkg::ST_IDLE) && (cnt_n < rdma_pkg::MAX_OUTSTANDING);
      if (sq_fire) next_psn <= next_psn + 1'b1;
      if (state_n == rdma_pkg::ST_IDLE) begin
        mem_taken <= 1'b0;
        hdr_taken <= 1'b0;
      end else begin
        mem_taken <= mem_done;
        hdr_taken <= hdr_done;
      end
    end
  end

  // Request payload, stamped with its PSN on admission
  always_ff @(posedge nclk) begin
    if (sq_fire) begin
      issue.req <= s_sq;
      issue.psn <= next_psn;
    end
  end

endmodule

// File: design/rdma_sq_top.sv
// Send-queue front end top level wiring control, command, header and ack blocks
`timescale 1ns/1ps

module rdma_sq_top (
  input  logic                nclk,
  input  logic                nresetn,
  input  rdma_pkg::rdma_sq_t  s_sq,
  input  logic                s_sq_valid,
  output logic                s_sq_ready,
  output rdma_pkg::mem_cmd_t  m_mem_rd,
  output logic                m_mem_rd_valid,
  input  logic                m_mem_rd_ready,
  output rdma_pkg::mem_cmd_t  m_mem_wr,
  output logic                m_mem_wr_valid,
  input  logic                m_mem_wr_ready,
  output rdma_pkg::tx_hdr_t   m_tx_hdr,
  output logic                m_tx_hdr_valid,
  input  logic                m_tx_hdr_ready,
  input  rdma_pkg::ack_pkt_t  s_ack,
  input  logic                s_ack_valid,
  output logic                s_ack_ready,
  output rdma_pkg::ack_meta_t m_ack,
  output logic                m_ack_valid,
  input  logic [31:0]         local_ip,
  output logic [31:0]         crc_drop_count,
  output logic [31:0]         psn_drop_count
);

  rdma_pkg::rdma_issue_t issue;
  logic                  issue_valid;
  logic                  mem_issue_ready;
  logic                  hdr_issue_ready;
  logic                  ack_done;

  rdma_sq_ctrl u_ctrl (
    .nclk            (nclk),
    .nresetn         (nresetn),
    .s_sq            (s_sq),
    .s_sq_valid      (s_sq_valid),
    .s_sq_ready      (s_sq_ready),
    .issue           (issue),
    .issue_valid     (issue_valid),
    .mem_issue_ready (mem_issue_ready),
    .hdr_issue_ready (hdr_issue_ready),
    .ack_done        (ack_done)
  );

  mem_cmd_gen u_mem_cmd (
    .nclk           (nclk),
    .nresetn        (nresetn),
    .issue          (issue),
    .issue_valid    (issue_valid),
    .issue_ready    (mem_issue_ready),
    .m_mem_rd       (m_mem_rd),
    .m_mem_rd_valid (m_mem_rd_valid),
    .m_mem_rd_ready (m_mem_rd_ready),
    .m_mem_wr       (m_mem_wr),
    .m_mem_wr_valid (m_mem_wr_valid),
    .m_mem_wr_ready (m_mem_wr_ready)
  );

  tx_hdr_gen u_tx_hdr (
    .nclk           (nclk),
    .nresetn        (nresetn),
    .issue          (issue),
    .issue_valid    (issue_valid),
    .issue_ready    (hdr_issue_ready),
    .local_ip       (local_ip),
    .m_tx_hdr       (m_tx_hdr),
    .m_tx_hdr_valid (m_tx_hdr_valid),
    .m_tx_hdr_ready (m_tx_hdr_ready)
  );

  rx_ack_check u_ack (
    .nclk           (nclk),
    .nresetn        (nresetn),
    .s_ack          (s_ack),
    .s_ack_valid    (s_ack_valid),
    .s_ack_ready    (s_ack_ready),
    .m_ack          (m_ack),
    .m_ack_valid    (m_ack_valid),
    .ack_done       (ack_done),
    .crc_drop_count (crc_drop_count),
    .psn_drop_count (psn_drop_count)
  );

endmodule

// File: design/rx_ack_check.sv
// Acknowledgement checker with byte checksum, expected PSN and drop counters
`timescale 1ns/1ps

module rx_ack_check (
  input  logic                nclk,
  input  logic                nresetn,
  input  rdma_pkg::ack_pkt_t  s_ack,
  input  logic                s_ack_valid,
  output logic                s_ack_ready,
  output rdma_pkg::ack_meta_t m_ack,
  output logic                m_ack_valid,
  output logic                ack_done,
  output logic [31:0]         crc_drop_count,
  output logic [31:0]         psn_drop_count
);

  logic [rdma_pkg::PSN_BITS-1:0] exp_psn;
  logic [15:0]                   qpn_ext;
  logic [7:0]                    chk_calc;
  logic                          chk_ok, psn_ok;

  // Acks are never back-pressured
  assign s_ack_ready = 1'b1;

  // XOR over qpn as two bytes, then the three psn bytes
  assign qpn_ext  = 16'(s_ack.qpn);
  assign chk_calc = qpn_ext[15:8] ^ qpn_ext[7:0] ^
                    s_ack.psn[23:16] ^ s_ack.psn[15:8] ^ s_ack.psn[7:0];
  assign chk_ok   = (chk_calc == s_ack.chk);
  assign psn_ok   = (s_ack.psn == exp_psn);

  // Every forwarded ack, NAK included, retires one request
  assign ack_done = m_ack_valid;

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      m_ack_valid    <= 1'b0;
      exp_psn        <= '0;
      crc_drop_count <= '0;
      psn_drop_count <= '0;
    end else begin
      m_ack_valid <= 1'b0;
      if (s_ack_valid) begin
        if (!chk_ok) begin
          crc_drop_count <= crc_drop_count + 1'b1;
        end else if (!psn_ok) begin
          psn_drop_count <= psn_drop_count + 1'b1;
        end else begin
          m_ack_valid <= 1'b1;
          exp_psn     <= exp_psn + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge nclk) begin
    if (s_ack_valid && chk_ok && psn_ok) begin
      m_ack.qpn    <= s_ack.qpn;
      m_ack.psn    <= s_ack.psn;
      m_ack.is_nak <= s_ack.is_nak;
    end
  end

endmodule

// File: design/tx_hdr_gen.sv
// Transmit header generator with user-to-wire opcode mapping
`timescale 1ns/1ps

module tx_hdr_gen (
  input  logic                   nclk,
  input  logic                   nresetn,
  input  rdma_pkg::rdma_issue_t  issue,
  input  logic                   issue_valid,
  output logic                   issue_ready,
  input  logic [31:0]            local_ip,
  output rdma_pkg::tx_hdr_t      m_tx_hdr,
  output logic                   m_tx_hdr_valid,
  input  logic                   m_tx_hdr_ready
);

  rdma_pkg::bth_op_e               bth_op;
  logic [rdma_pkg::PSN_BITS-1:0]   last_psn;
  logic                            seen, dup, take;

  always_comb begin
    case (issue.req.op)
      rdma_pkg::OP_READ:  bth_op = rdma_pkg::BTH_READ_REQ;
      rdma_pkg::OP_WRITE: bth_op = rdma_pkg::BTH_WRITE_ONLY;
      default:            bth_op = rdma_pkg::BTH_SEND_ONLY;
    endcase
  end

  // Ignore a request already taken, PSNs are unique per issue
  assign dup         = seen && (issue.psn == last_psn);
  assign issue_ready = (~m_tx_hdr_valid | m_tx_hdr_ready) & ~dup;
  assign take        = issue_valid & issue_ready;

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      m_tx_hdr_valid <= 1'b0;
      seen           <= 1'b0;
    end else if (take) begin
      m_tx_hdr_valid <= 1'b1;
      seen           <= 1'b1;
    end else if (m_tx_hdr_ready) begin
      m_tx_hdr_valid <= 1'b0;
    end
  end

  always_ff @(posedge nclk) begin
    if (take) begin
      m_tx_hdr.bth_op <= bth_op;
      m_tx_hdr.qpn    <= issue.req.qpn;
      m_tx_hdr.psn    <= issue.psn;
      m_tx_hdr.len    <= issue.req.len;
      // IPv4 source only
      m_tx_hdr.src_ip <= local_ip;
      last_psn        <= issue.psn;
    end
  end

endmodule

// File: tests/tb_rdma_sq.sv
// Directed testbench for the send-queue front end with PSN and ack models
`timescale 1ns/1ps

module tb_rdma_sq;

  localparam int          WAIT_LIMIT = 50;
  localparam logic [31:0] SEED       = 32'h6dc4_907f;
  localparam logic [31:0] LOCAL_IP   = 32'hc0a8_0a15;

  logic                nclk;
  logic                nresetn;
  rdma_pkg::rdma_sq_t  s_sq;
  logic                s_sq_valid;
  logic                s_sq_ready;
  rdma_pkg::mem_cmd_t  m_mem_rd;
  logic                m_mem_rd_valid;
  logic                m_mem_rd_ready;
  rdma_pkg::mem_cmd_t  m_mem_wr;
  logic                m_mem_wr_valid;
  logic                m_mem_wr_ready;
  rdma_pkg::tx_hdr_t   m_tx_hdr;
  logic                m_tx_hdr_valid;
  logic                m_tx_hdr_ready;
  rdma_pkg::ack_pkt_t  s_ack;
  logic                s_ack_valid;
  logic                s_ack_ready;
  rdma_pkg::ack_meta_t m_ack;
  logic                m_ack_valid;
  logic [31:0]         local_ip;
  logic [31:0]         crc_drop_count;
  logic [31:0]         psn_drop_count;

  // Reference model state
  logic [23:0] next_psn;
  logic [23:0] exp_ack_psn;
  int          outstanding;
  int          crc_drops_exp;
  int          psn_drops_exp;
  int          errors;
  int          checks;
  logic [31:0] rnd;

  rdma_sq_top UUT (
    .nclk           (nclk),
    .nresetn        (nresetn),
    .s_sq           (s_sq),
    .s_sq_valid     (s_sq_valid),
    .s_sq_ready     (s_sq_ready),
    .m_mem_rd       (m_mem_rd),
    .m_mem_rd_valid (m_mem_rd_valid),
    .m_mem_rd_ready (m_mem_rd_ready),
    .m_mem_wr       (m_mem_wr),
    .m_mem_wr_valid (m_mem_wr_valid),
    .m_mem_wr_ready (m_mem_wr_ready),
    .m_tx_hdr       (m_tx_hdr),
    .m_tx_hdr_valid (m_tx_hdr_valid),
    .m_tx_hdr_ready (m_tx_hdr_ready),
    .s_ack          (s_ack),
    .s_ack_valid    (s_ack_valid),
    .s_ack_ready    (s_ack_ready),
    .m_ack          (m_ack),
    .m_ack_valid    (m_ack_valid),
    .local_ip       (local_ip),
    .crc_drop_count (crc_drop_count),
    .psn_drop_count (psn_drop_count)
  );

  initial begin
    nclk = 1'b0;
    forever #20 nclk = ~nclk;
  end

  task automatic compare_hex(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  function automatic logic valid_of(input int sel);
    case (sel)
      0:       return m_mem_rd_valid;
      1:       return m_mem_wr_valid;
      2:       return m_tx_hdr_valid;
      3:       return m_ack_valid;
      default: return s_sq_ready;
    endcase
  endfunction

  // Checks the current falling edge first, then steps one cycle at a time
  task automatic wait_valid(input int sel, input string name, output bit ok);
    int i;
    i = 0;
    while (!valid_of(sel) && i < WAIT_LIMIT) begin
      @(negedge nclk);
      i++;
    end
    ok = valid_of(sel);
    if (!ok) begin
      errors++;
      $display("Timed out after %0d cycles waiting for %s to go high", WAIT_LIMIT, name);
    end
  endtask

  function automatic logic [7:0] wire_opcode(input rdma_pkg::rdma_op_e op);
    case (op)
      rdma_pkg::OP_READ:  return 8'h0C;
      rdma_pkg::OP_WRITE: return 8'h0A;
      default:            return 8'h04;
    endcase
  endfunction

  // XOR of qpn as two bytes and the three psn bytes
  function automatic logic [7:0] ack_checksum(input logic [9:0] qpn, input logic [23:0] psn);
    logic [15:0] q;
    q = {6'b0, qpn};
    return q[15:8] ^ q[7:0] ^ psn[23:16] ^ psn[15:8] ^ psn[7:0];
  endfunction

  function automatic rdma_pkg::rdma_sq_t make_request(input rdma_pkg::rdma_op_e op);
    rdma_pkg::rdma_sq_t r;
    logic [31:0] hi;
    logic [31:0] lo;
    logic [31:0] ln;
    hi = $urandom;
    lo = $urandom;
    ln = $urandom;
    r.op    = op;
    r.qpn   = hi[25:16];
    r.vaddr = {hi[15:0], lo};
    r.len   = ln[27:0];
    return r;
  endfunction

  task automatic send_request(input rdma_pkg::rdma_sq_t req, output logic [23:0] psn,
                              output bit ok);
    int i;
    @(negedge nclk);
    s_sq       = req;
    s_sq_valid = 1'b1;
    i = 0;
    while (!s_sq_ready && i < WAIT_LIMIT) begin
      @(negedge nclk);
      i++;
    end
    ok = s_sq_ready;
    psn = next_psn;
    if (ok) begin
      @(negedge nclk);
      next_psn = next_psn + 1'b1;
      outstanding++;
    end else begin
      errors++;
      $display("Timed out waiting for s_sq_ready to accept a request");
    end
    s_sq_valid = 1'b0;
  endtask

  task automatic send_ack(input logic [9:0] qpn, input logic [23:0] psn, input logic nak,
                          input logic [7:0] chk);
    int i;
    @(negedge nclk);
    s_ack.qpn    = qpn;
    s_ack.psn    = psn;
    s_ack.is_nak = nak;
    s_ack.chk    = chk;
    s_ack_valid  = 1'b1;
    i = 0;
    while (!s_ack_ready && i < WAIT_LIMIT) begin
      @(negedge nclk);
      i++;
    end
    if (!s_ack_ready) begin
      errors++;
      $display("Timed out waiting for s_ack_ready");
    end
    @(negedge nclk);
    s_ack_valid = 1'b0;
  endtask

  task automatic expect_mem(input rdma_pkg::rdma_sq_t req);
    bit                 ok;
    logic               fetch;
    rdma_pkg::mem_cmd_t cmd;
    fetch = (req.op != rdma_pkg::OP_READ);
    if (fetch) wait_valid(0, "m_mem_rd_valid", ok);
    else wait_valid(1, "m_mem_wr_valid", ok);
    if (ok) begin
      cmd = fetch ? m_mem_rd : m_mem_wr;
      compare_hex("mem_cmd.vaddr", cmd.vaddr, req.vaddr);
      compare_hex("mem_cmd.len", cmd.len, req.len);
      compare_hex("mem_cmd.qpn", cmd.qpn, req.qpn);
      // Only one of the two ports may carry the command
      if (fetch) compare_hex("m_mem_wr_valid", m_mem_wr_valid, 0);
      else compare_hex("m_mem_rd_valid", m_mem_rd_valid, 0);
    end
  endtask

  task automatic expect_hdr(input rdma_pkg::rdma_sq_t req, input logic [23:0] psn);
    bit ok;
    wait_valid(2, "m_tx_hdr_valid", ok);
    if (ok) begin
      compare_hex("m_tx_hdr.bth_op", m_tx_hdr.bth_op, wire_opcode(req.op));
      compare_hex("m_tx_hdr.qpn", m_tx_hdr.qpn, req.qpn);
      compare_hex("m_tx_hdr.psn", m_tx_hdr.psn, psn);
      compare_hex("m_tx_hdr.len", m_tx_hdr.len, req.len);
      compare_hex("m_tx_hdr.src_ip", m_tx_hdr.src_ip, LOCAL_IP);
    end
  endtask

  // Good ack or NAK for the oldest outstanding PSN
  task automatic ack_next(input logic nak);
    bit         ok;
    logic [9:0] qpn;
    rnd = $urandom;
    qpn = rnd[9:0];
    send_ack(qpn, exp_ack_psn, nak, ack_checksum(qpn, exp_ack_psn));
    wait_valid(3, "m_ack_valid", ok);
    if (ok) begin
      compare_hex("m_ack.qpn", m_ack.qpn, qpn);
      compare_hex("m_ack.psn", m_ack.psn, exp_ack_psn);
      compare_hex("m_ack.is_nak", m_ack.is_nak, nak);
    end
    exp_ack_psn = exp_ack_psn + 1'b1;
    outstanding--;
  endtask

  task automatic hold_not_ready(input int cycles);
    repeat (cycles) begin
      @(negedge nclk);
      compare_hex("s_sq_ready", s_sq_ready, 0);
    end
  endtask

  task automatic reset_state;
    compare_hex("m_mem_rd_valid", m_mem_rd_valid, 0);
    compare_hex("m_mem_wr_valid", m_mem_wr_valid, 0);
    compare_hex("m_tx_hdr_valid", m_tx_hdr_valid, 0);
    compare_hex("m_ack_valid", m_ack_valid, 0);
    compare_hex("crc_drop_count", crc_drop_count, 0);
    compare_hex("psn_drop_count", psn_drop_count, 0);
    compare_hex("s_sq_ready", s_sq_ready, 1);
  endtask

  task automatic write_send_flow;
    rdma_pkg::rdma_sq_t req;
    logic [23:0]        psn;
    bit                 ok;
    req = make_request(rdma_pkg::OP_WRITE);
    send_request(req, psn, ok);
    expect_mem(req);
    expect_hdr(req, psn);
    @(negedge nclk);
    compare_hex("m_mem_rd_valid", m_mem_rd_valid, 0);
    req = make_request(rdma_pkg::OP_SEND);
    send_request(req, psn, ok);
    expect_mem(req);
    expect_hdr(req, psn);
    @(negedge nclk);
    compare_hex("m_mem_rd_valid", m_mem_rd_valid, 0);
    compare_hex("m_tx_hdr_valid", m_tx_hdr_valid, 0);
  endtask

  task automatic read_with_backpressure;
    rdma_pkg::rdma_sq_t req;
    rdma_pkg::tx_hdr_t  held;
    logic [23:0]        psn;
    bit                 ok;
    req = make_request(rdma_pkg::OP_READ);
    @(negedge nclk);
    m_tx_hdr_ready = 1'b0;
    send_request(req, psn, ok);
    expect_mem(req);
    wait_valid(2, "m_tx_hdr_valid", ok);
    held = m_tx_hdr;
    // Header must sit unchanged while the sink stalls
    repeat (4) begin
      @(negedge nclk);
      compare_hex("m_tx_hdr_valid", m_tx_hdr_valid, 1);
      compare_hex("m_tx_hdr", m_tx_hdr, held);
    end
    expect_hdr(req, psn);
    m_tx_hdr_ready = 1'b1;
    @(negedge nclk);
    compare_hex("m_tx_hdr_valid", m_tx_hdr_valid, 0);
  endtask

  task automatic ack_filtering;
    logic [9:0] qpn;
    ack_next(1'b0);
    qpn = 10'h2a5;
    send_ack(qpn, exp_ack_psn, 1'b0, ack_checksum(qpn, exp_ack_psn) ^ 8'h5a);
    crc_drops_exp++;
    compare_hex("crc_drop_count", crc_drop_count, crc_drops_exp);
    compare_hex("psn_drop_count", psn_drop_count, psn_drops_exp);
    compare_hex("m_ack_valid", m_ack_valid, 0);
    send_ack(qpn, exp_ack_psn + 24'd5, 1'b0, ack_checksum(qpn, exp_ack_psn + 24'd5));
    psn_drops_exp++;
    compare_hex("psn_drop_count", psn_drop_count, psn_drops_exp);
    compare_hex("crc_drop_count", crc_drop_count, crc_drops_exp);
    compare_hex("m_ack_valid", m_ack_valid, 0);
    @(negedge nclk);
    compare_hex("m_ack_valid", m_ack_valid, 0);
  endtask

  task automatic outstanding_limit;
    rdma_pkg::rdma_sq_t req;
    logic [23:0]        psn;
    bit                 ok;
    while (outstanding > 0) ack_next(1'b0);
    repeat (8) begin
      req = make_request(rdma_pkg::OP_WRITE);
      send_request(req, psn, ok);
      expect_mem(req);
      expect_hdr(req, psn);
    end
    hold_not_ready(6);
    ack_next(1'b0);
    wait_valid(4, "s_sq_ready", ok);
    req = make_request(rdma_pkg::OP_SEND);
    send_request(req, psn, ok);
    expect_mem(req);
    expect_hdr(req, psn);
    hold_not_ready(6);
  endtask

  task automatic nak_release;
    rdma_pkg::rdma_sq_t req;
    logic [23:0]        psn;
    bit                 ok;
    ack_next(1'b1);
    wait_valid(4, "s_sq_ready", ok);
    req = make_request(rdma_pkg::OP_READ);
    send_request(req, psn, ok);
    expect_mem(req);
    expect_hdr(req, psn);
    hold_not_ready(4);
  endtask

  initial begin
    nresetn        = 1'b0;
    s_sq           = '0;
    s_sq_valid     = 1'b0;
    m_mem_rd_ready = 1'b1;
    m_mem_wr_ready = 1'b1;
    m_tx_hdr_ready = 1'b1;
    s_ack          = '0;
    s_ack_valid    = 1'b0;
    local_ip       = LOCAL_IP;
    next_psn       = '0;
    exp_ack_psn    = '0;
    outstanding    = 0;
    crc_drops_exp  = 0;
    psn_drops_exp  = 0;
    errors         = 0;
    checks         = 0;
    rnd            = $urandom(SEED);
    repeat (5) @(negedge nclk);
    nresetn = 1'b1;
    @(negedge nclk);
    reset_state();
    write_send_flow();
    read_with_backpressure();
    ack_filtering();
    outstanding_limit();
    nak_release();
    repeat (2) @(negedge nclk);
    $display("Run complete: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
